/* common/gpio_slave_pkg.sv */
`default_nettype none

package gpio_slave_pkg;

	//////////////////////////////////////////////////
	// widths

	// bus address and data
	typedef logic [31:0] addr_t;
	typedef logic [31:0] data_t;

	// word index inside one 256-bit block
	typedef logic [2:0] word_idx_t;

	// whole GPO or GPI vector, eight words
	typedef logic [255:0] gpio_vec_t;

	// one strobe per GPO word
	typedef logic [7:0] word_strobe_t;

	// wait-state counter, needs to hold up to 3
	typedef logic [1:0] wait_cnt_t;

	//////////////////////////////////////////////////
	// register map

	// GPO words start here
	localparam addr_t GPIO_BASE_ADDR = 32'h0100_0000;

	// GPI words follow the GPO block
	localparam addr_t GPI_OFFSET = 32'h0000_0020;

	// words per block
	localparam int GPIO_WORDS = 8;

	// byte stride between words
	localparam int WORD_BYTES = 4;

	//////////////////////////////////////////////////
	// transfer timing

	// wait states before ready
	localparam wait_cnt_t WRITE_WAIT_STATES = 2'd2;
	localparam wait_cnt_t READ_WAIT_STATES = 2'd3;

	// transfer controller states
	typedef enum logic [1:0] {
		XFER_IDLE,
		XFER_WAIT,
		XFER_RESP
	} xfer_state_e;

endpackage : gpio_slave_pkg

`default_nettype wire

/* common/gpio_access_if.sv */
`timescale 1ns/1ns
`default_nettype none

interface gpio_access_if;

	// word picked out of the addressed block
	gpio_slave_pkg::word_idx_t word_sel;

	// write request to the GPO bank
	logic wr_en;
	gpio_slave_pkg::data_t wr_data;

	// read-back words from both blocks
	gpio_slave_pkg::data_t gpo_word;
	gpio_slave_pkg::data_t gpi_word;

	// transfer controller side
	modport ctrl (
		output word_sel,
		output wr_en,
		output wr_data,
		input gpo_word,
		input gpi_word
	);

	// GPO bank side, write and read-back
	modport gpo (
		input word_sel,
		input wr_en,
		input wr_data,
		output gpo_word
	);

	// GPI port side, read only
	modport gpi (
		input word_sel,
		output gpi_word
	);

endinterface : gpio_access_if

`default_nettype wire

/* design/gpi_read_port.sv */
`timescale 1ns/1ns
`default_nettype none

module gpi_read_port (
	input wire rst_n,
	input wire BUS_agnt_vi,
	gpio_access_if.gpi acc,
	input wire gpio_slave_pkg::gpio_vec_t gp_ip
);

	// two-flop synchroniser stages
	gpio_slave_pkg::gpio_vec_t gpi_meta;
	gpio_slave_pkg::gpio_vec_t gpi_sync;

	//////////////////////////////////////////////////
	// synchroniser

	// inputs come from outside the clock domain
	always_ff @(posedge BUS_agnt_vi) begin
		if (!rst_n) begin
			gpi_meta <= '0;
			gpi_sync <= '0;
		end else begin
			gpi_meta <= gp_ip;
			gpi_sync <= gpi_meta;
		end
	end

	//////////////////////////////////////////////////
	// word select

	// settled copy only, never the first stage
	assign acc.gpi_word = gpi_sync[acc.word_sel * $bits(gpio_slave_pkg::data_t) +:
		$bits(gpio_slave_pkg::data_t)];

endmodule : gpi_read_port

`default_nettype wire

/* design/gpo_register_bank.sv */
`timescale 1ns/1ns
`default_nettype none

module gpo_register_bank (
	input wire rst_n,
	input wire BUS_agnt_vi,
	gpio_access_if.gpo acc,
	output gpio_slave_pkg::gpio_vec_t gp_op,
	output gpio_slave_pkg::word_strobe_t gp_op_valid
);

	//////////////////////////////////////////////////
	// output register and strobes

	always_ff @(posedge BUS_agnt_vi) begin
		if (!rst_n) begin
			gp_op <= '0;
			gp_op_valid <= '0;
		end else begin
			// strobe lasts one cycle only
			gp_op_valid <= '0;
			if (acc.wr_en) begin
				// one 32-bit slice per word
				gp_op[acc.word_sel * $bits(gpio_slave_pkg::data_t) +:
					$bits(gpio_slave_pkg::data_t)] <= acc.wr_data;
				// flag the word just written
				gp_op_valid[acc.word_sel] <= 1'b1;
			end
		end
	end

	//////////////////////////////////////////////////
	// read-back

	// selected word, no extra register stage
	assign acc.gpo_word = gp_op[acc.word_sel * $bits(gpio_slave_pkg::data_t) +:
		$bits(gpio_slave_pkg::data_t)];

endmodule : gpo_register_bank

`default_nettype wire

/* design/bus_transfer_ctrl.sv */
`timescale 1ns/1ns
`default_nettype none

module bus_transfer_ctrl (
	input wire rst_n,
	input wire BUS_agnt_vi,
	input wire gpio_slave_pkg::addr_t addr,
	input wire gpio_slave_pkg::data_t write_data,
	input wire rnw,
	input wire valid,
	output logic ready,
	output gpio_slave_pkg::data_t read_data,
	output logic error,
	gpio_access_if.ctrl acc
);

	gpio_slave_pkg::xfer_state_e state;
	gpio_slave_pkg::wait_cnt_t wait_cnt;

	// address decode
	logic aligned;
	logic gpo_hit;
	logic gpi_hit;
	logic access_ok;

	// last wait cycle, response goes out on the next edge
	logic last_wait;

	// region bounds
	gpio_slave_pkg::addr_t gpi_base;
	gpio_slave_pkg::addr_t gpi_end;

	//////////////////////////////////////////////////
	// address decode

	assign gpi_base = gpio_slave_pkg::GPIO_BASE_ADDR + gpio_slave_pkg::GPI_OFFSET;
	assign gpi_end = gpi_base + gpio_slave_pkg::addr_t'(
		gpio_slave_pkg::GPIO_WORDS * gpio_slave_pkg::WORD_BYTES);

	// low address bits must be zero
	assign aligned = (addr[$clog2(gpio_slave_pkg::WORD_BYTES)-1:0] == '0);

	// GPO words sit between base and the GPI block
	assign gpo_hit = aligned
		&& (addr >= gpio_slave_pkg::GPIO_BASE_ADDR)
		&& (addr < gpi_base);

	// GPI words, eight of them after the offset
	assign gpi_hit = aligned
		&& (addr >= gpi_base)
		&& (addr < gpi_end);

	// writes only into GPO, reads from either block
	assign access_ok = rnw ? (gpo_hit || gpi_hit) : gpo_hit;

	//////////////////////////////////////////////////
	// access path to the register blocks

	// same word index for both blocks
	assign acc.word_sel = addr[$clog2(gpio_slave_pkg::WORD_BYTES) +:
		$bits(gpio_slave_pkg::word_idx_t)];

	assign acc.wr_data = write_data;

	assign last_wait = (state == gpio_slave_pkg::XFER_WAIT) && (wait_cnt == '0);

	// bank takes the word at the edge that raises ready
	assign acc.wr_en = last_wait && !rnw && gpo_hit;

	//////////////////////////////////////////////////
	// transfer FSM

	always_ff @(posedge BUS_agnt_vi) begin
		if (!rst_n) begin
			state <= gpio_slave_pkg::XFER_IDLE;
			wait_cnt <= '0;
			ready <= 1'b0;
			error <= 1'b0;
			read_data <= '0;
		end else begin
			// response flags are single pulses
			ready <= 1'b0;
			error <= 1'b0;
			case (state)
				gpio_slave_pkg::XFER_IDLE: begin
					// load the wait count for this direction
					if (valid) begin
						state <= gpio_slave_pkg::XFER_WAIT;
						wait_cnt <= rnw ? gpio_slave_pkg::READ_WAIT_STATES
							: gpio_slave_pkg::WRITE_WAIT_STATES;
					end
				end
				gpio_slave_pkg::XFER_WAIT: begin
					if (wait_cnt == '0) begin
						state <= gpio_slave_pkg::XFER_RESP;
						ready <= 1'b1;
						error <= !access_ok;
						// failed reads return zero
						if (rnw) begin
							if (gpi_hit) begin
								read_data <= acc.gpi_word;
							end else if (gpo_hit) begin
								read_data <= acc.gpo_word;
							end else begin
								read_data <= '0;
							end
						end
					end else begin
						wait_cnt <= wait_cnt - 1'b1;
					end
				end
				gpio_slave_pkg::XFER_RESP: begin
					// master drops valid during the ready cycle
					state <= gpio_slave_pkg::XFER_IDLE;
				end
				default: begin
					state <= gpio_slave_pkg::XFER_IDLE;
				end
			endcase
		end
	end

endmodule : bus_transfer_ctrl

`default_nettype wire

/* design/gpio_bus_slave.sv */
`timescale 1ns/1ns
`default_nettype none

module gpio_bus_slave (
	input wire rst_n,
	input wire BUS_agnt_vi,
	// register bus
	input wire gpio_slave_pkg::addr_t addr,
	input wire gpio_slave_pkg::data_t write_data,
	input wire rnw,
	input wire valid,
	output wire ready,
	output wire gpio_slave_pkg::data_t read_data,
	output wire error,
	// general-purpose pins
	output wire gpio_slave_pkg::gpio_vec_t gp_op,
	output wire gpio_slave_pkg::word_strobe_t gp_op_valid,
	input wire gpio_slave_pkg::gpio_vec_t gp_ip
);

	//////////////////////////////////////////////////
	// shared access path to both register blocks

	gpio_access_if acc ();

	//////////////////////////////////////////////////
	// bus side, decode and wait states

	bus_transfer_ctrl u_ctrl (
		.rst_n (rst_n),
		.BUS_agnt_vi (BUS_agnt_vi),
		.addr (addr),
		.write_data (write_data),
		.rnw (rnw),
		.valid (valid),
		.ready (ready),
		.read_data (read_data),
		.error (error),
		.acc (acc.ctrl)
	);

	//////////////////////////////////////////////////
	// register blocks, side by side

	// output words and their strobes
	gpo_register_bank u_gpo (
		.rst_n (rst_n),
		.BUS_agnt_vi (BUS_agnt_vi),
		.acc (acc.gpo),
		.gp_op (gp_op),
		.gp_op_valid (gp_op_valid)
	);

	// synchronised inputs
	gpi_read_port u_gpi (
		.rst_n (rst_n),
		.BUS_agnt_vi (BUS_agnt_vi),
		.acc (acc.gpi),
		.gp_ip (gp_ip)
	);

endmodule : gpio_bus_slave

`default_nettype wire

/* bench/gpio_bus_tasks.svh */
`ifndef GPIO_BUS_TASKS_SVH
`define GPIO_BUS_TASKS_SVH

//////////////////////////////////////////////////
// random source

// galois form with taps 32 31 29 1
function automatic logic [31:0] lfsr_step(input logic [31:0] s);
	if (s[0]) begin
		return (s >> 1) ^ 32'hD000_0001;
	end
	return s >> 1;
endfunction

// one step per bit taken
function automatic gpio_slave_pkg::data_t random_word();
	gpio_slave_pkg::data_t word;
	int b;
	word = '0;
	for (b = 0; b < 32; b++) begin
		lfsr = lfsr_step(lfsr);
		word = {word[30:0], lfsr[0]};
	end
	return word;
endfunction

//////////////////////////////////////////////////
// checks

task automatic check_word(input string name, input logic [31:0] expected,
	input logic [31:0] actual);
	check_count++;
	assert (actual === expected) else begin
		mismatch_count++;
		$display("Mismatch in %s: expected %h, actual %h", name, expected, actual);
	end
endtask

// whole output vector against the model
task automatic check_gpo(input string name);
	int w;
	for (w = 0; w < 8; w++) begin
		check_word($sformatf("%s word %0d", name, w), gpo_model[w], gp_op[w * 32 +: 32]);
	end
endtask

//////////////////////////////////////////////////
// bus transfers

// drive one transfer and sample the response at ready
task automatic bus_transfer(input string name, input logic is_read,
	input gpio_slave_pkg::addr_t a, input gpio_slave_pkg::data_t wdata,
	output gpio_slave_pkg::data_t rdata, output logic err,
	output gpio_slave_pkg::word_strobe_t strobe);
	int edges;
	logic seen;
	@(negedge BUS_agnt_vi);
	addr = a;
	rnw = is_read;
	write_data = wdata;
	valid = 1'b1;
	edges = 0;
	seen = 1'b0;
	// one falling edge per rising edge since valid
	while (!seen && edges < 20) begin
		@(negedge BUS_agnt_vi);
		edges++;
		seen = ready;
	end
	rdata = read_data;
	err = error;
	strobe = gp_op_valid;
	// drop valid inside the ready cycle
	valid = 1'b0;
	if (!seen) begin
		failure_count++;
		$display("%s: no ready within 20 cycles of valid", name);
	end else begin
		// first edge only samples valid
		check_word({name, " latency"}, is_read ? 4 : 3, edges - 1);
	end
endtask

// access that the slave must reject
task automatic expect_error(input string name, input logic is_read,
	input gpio_slave_pkg::addr_t a);
	gpio_slave_pkg::data_t rdata;
	gpio_slave_pkg::word_strobe_t strobe;
	logic err;
	bus_transfer(name, is_read, a, random_word(), rdata, err, strobe);
	check_word({name, " error"}, 1, err);
	check_word({name, " strobe"}, 0, strobe);
	check_gpo({name, " gp_op"});
endtask

`endif

/* bench/gpio_bus_slave_tb.sv */
`timescale 1ns/1ns
`default_nettype none

module gpio_bus_slave_tb;

	logic rst_n;
	logic BUS_agnt_vi;
	gpio_slave_pkg::addr_t addr;
	gpio_slave_pkg::data_t write_data;
	logic rnw;
	logic valid;
	logic ready;
	gpio_slave_pkg::data_t read_data;
	logic error;
	gpio_slave_pkg::gpio_vec_t gp_op;
	gpio_slave_pkg::word_strobe_t gp_op_valid;
	gpio_slave_pkg::gpio_vec_t gp_ip;

	// expected GPO words, updated on every good write
	gpio_slave_pkg::data_t gpo_model [8];

	// result counters
	int check_count;
	int mismatch_count;
	int failure_count;

	// random source state
	logic [31:0] lfsr;

	`include "gpio_bus_tasks.svh"

	gpio_bus_slave DUT (
		.rst_n (rst_n),
		.BUS_agnt_vi (BUS_agnt_vi),
		.addr (addr),
		.write_data (write_data),
		.rnw (rnw),
		.valid (valid),
		.ready (ready),
		.read_data (read_data),
		.error (error),
		.gp_op (gp_op),
		.gp_op_valid (gp_op_valid),
		.gp_ip (gp_ip)
	);

	// 20 ns period
	initial begin
		BUS_agnt_vi = 1'b0;
		forever #10 BUS_agnt_vi = ~BUS_agnt_vi;
	end

	//////////////////////////////////////////////////
	// protocol assertions

	// ready is a single pulse
	assert property (@(posedge BUS_agnt_vi) disable iff (!rst_n) ready |=> !ready)
		else begin
			failure_count++;
			$display("ready stayed high for more than one cycle at %0t", $time);
		end

	// error only together with ready
	assert property (@(posedge BUS_agnt_vi) disable iff (!rst_n) error |-> ready)
		else begin
			failure_count++;
			$display("error was raised without ready at %0t", $time);
		end

	// a strobe marks exactly one word, in the ready cycle
	assert property (@(posedge BUS_agnt_vi) disable iff (!rst_n)
		(gp_op_valid != '0) |-> (ready && $onehot(gp_op_valid)))
		else begin
			failure_count++;
			$display("gp_op_valid pulsed outside a single-word write at %0t", $time);
		end

	// closing line, then the verdict
	task automatic finish_run();
		$display("checks %0d, mismatches %0d, other failures %0d",
			check_count, mismatch_count, failure_count);
		if (mismatch_count == 0 && failure_count == 0) begin
			$display("Everything OK");
		end else begin
			$display("Something failed");
		end
		$finish;
	endtask

	//////////////////////////////////////////////////
	// test sequence

	initial begin
		gpio_slave_pkg::data_t wdata;
		gpio_slave_pkg::data_t rdata;
		gpio_slave_pkg::word_strobe_t strobe;
		logic err;
		int i;
		int r;
		// idle bus, reset held
		rst_n = 1'b0;
		addr = '0;
		write_data = '0;
		rnw = 1'b0;
		valid = 1'b0;
		gp_ip = '0;
		check_count = 0;
		mismatch_count = 0;
		failure_count = 0;
		lfsr = 32'h51e5edab;
		for (i = 0; i < 8; i++) begin
			gpo_model[i] = '0;
		end
		repeat (8) @(negedge BUS_agnt_vi);
		rst_n = 1'b1;
		@(negedge BUS_agnt_vi);

		// everything quiet out of reset
		check_word("reset ready", 0, ready);
		check_word("reset error", 0, error);
		check_word("reset read_data", 0, read_data);
		check_word("reset gp_op_valid", 0, gp_op_valid);
		check_gpo("reset gp_op");

		// one write per GPO word
		for (i = 0; i < 8; i++) begin
			wdata = random_word();
			bus_transfer("gpo write", 1'b0, 32'h0100_0000 + 4 * i, wdata, rdata, err, strobe);
			gpo_model[i] = wdata;
			check_word("gpo write error", 0, err);
			check_word("gpo write strobe", 32'h1 << i, strobe);
			check_gpo("gpo write gp_op");
		end

		// read back what was written
		for (i = 0; i < 8; i++) begin
			bus_transfer("gpo read", 1'b1, 32'h0100_0000 + 4 * i, '0, rdata, err, strobe);
			check_word("gpo read data", gpo_model[i], rdata);
			check_word("gpo read error", 0, err);
		end

		// two rounds of fresh input patterns
		for (r = 0; r < 2; r++) begin
			for (i = 0; i < 8; i++) begin
				gp_ip[i * 32 +: 32] = random_word();
			end
			// let the synchroniser settle
			repeat (3) @(negedge BUS_agnt_vi);
			for (i = 0; i < 8; i++) begin
				bus_transfer("gpi read", 1'b1, 32'h0100_0020 + 4 * i, '0, rdata, err, strobe);
				check_word("gpi read data", gp_ip[i * 32 +: 32], rdata);
				check_word("gpi read error", 0, err);
			end
		end

		// rejected accesses
		expect_error("write into gpi", 1'b0, 32'h0100_0020);
		expect_error("write into gpi top", 1'b0, 32'h0100_003C);
		expect_error("write above range", 1'b0, 32'h0100_0040);
		expect_error("read above range", 1'b1, 32'h0100_0040);
		expect_error("write below base", 1'b0, 32'h00FF_FFFC);
		expect_error("read below base", 1'b1, 32'h00FF_FFFC);
		expect_error("misaligned write", 1'b0, 32'h0100_0002);
		expect_error("misaligned read", 1'b1, 32'h0100_0021);

		@(negedge BUS_agnt_vi);
		finish_run();
	end

endmodule : gpio_bus_slave_tb

`default_nettype wire

/* sources.f */
+incdir+bench
common/gpio_slave_pkg.sv
common/gpio_access_if.sv
design/gpi_read_port.sv
design/gpo_register_bank.sv
design/bus_transfer_ctrl.sv
design/gpio_bus_slave.sv
bench/gpio_bus_slave_tb.sv

/* Bender.yml */
package:
  name: gpio_bus_slave

sources:
  - files:
      - common/gpio_slave_pkg.sv
      - common/gpio_access_if.sv
      - design/gpi_read_port.sv
      - design/gpo_register_bank.sv
      - design/bus_transfer_ctrl.sv
      - design/gpio_bus_slave.sv
  - target: test
    include_dirs:
      - bench
    files:
      - bench/gpio_bus_slave_tb.sv
